// File: src/divsqrt_pkg.sv
// unsigned operands only; one fixed width for divide and square root, no signed mode
package divsqrt_pkg;

  // --------------------------------------------------
  // widths
  // --------------------------------------------------
  // divide operand, quotient and root
  localparam int unsigned DATA_W = 32;
  // radicand, also the full operand word
  localparam int unsigned RAD_W = 2 * DATA_W;
  // opaque tag, carried past the unit
  localparam int unsigned TAG_W = 4;
  // one quotient bit or one root bit per step
  localparam int unsigned NUM_ITER = DATA_W;

  // --------------------------------------------------
  // opcode
  // --------------------------------------------------
  typedef enum logic {
    OP_DIV  = 1'b0,
    OP_SQRT = 1'b1
  } divsqrt_op_e;

  // --------------------------------------------------
  // operand word
  // --------------------------------------------------
  // dividend on top, divisor below
  typedef struct packed {
    logic [DATA_W-1:0] dividend;
    logic [DATA_W-1:0] divisor;
  } div_operands_t;

  // same 64 bits, read per opcode
  typedef union packed {
    div_operands_t     div;
    logic [RAD_W-1:0]  radicand;
  } operand_u;

  // --------------------------------------------------
  // payloads
  // --------------------------------------------------
  // 69 bits on the request side
  typedef struct packed {
    divsqrt_op_e      op;
    operand_u         operands;
    logic [TAG_W-1:0] tag;
  } req_payload_t;

  // 37 bits on the response side
  typedef struct packed {
    logic [DATA_W-1:0] result;
    logic              dz;
    logic [TAG_W-1:0]  tag;
  } rsp_payload_t;

endpackage

// File: src/divsqrt_intf.sv
// valid never waits on ready; a transfer is valid and ready high on the same rising edge

// --------------------------------------------------
// request bundle
// --------------------------------------------------
interface divsqrt_req_if;
  import divsqrt_pkg::*;

  logic             valid;
  logic             ready;
  divsqrt_op_e      op;
  operand_u         operands;
  logic [TAG_W-1:0] tag;

  // sender side, owns valid and payload
  modport producer (
    output valid,
    output op,
    output operands,
    output tag,
    input  ready
  );

  // receiver side, owns ready only
  modport consumer (
    input  valid,
    input  op,
    input  operands,
    input  tag,
    output ready
  );

endinterface

// --------------------------------------------------
// response bundle
// --------------------------------------------------
interface divsqrt_rsp_if;
  import divsqrt_pkg::*;

  logic              valid;
  logic              ready;
  logic [DATA_W-1:0] result;
  logic              dz;
  logic [TAG_W-1:0]  tag;

  modport producer (
    output valid,
    output result,
    output dz,
    output tag,
    input  ready
  );

  modport consumer (
    input  valid,
    input  result,
    input  dz,
    input  tag,
    output ready
  );

endinterface

// File: src/divsqrt_pipe_reg.sv
// single-entry stage; flush drops the held item, an item offered during flush is also lost
module divsqrt_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     flush_i,
  // upstream side
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  // downstream side
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  // take a new item when empty or when the current one leaves
  assign ready_o = ready_i | ~valid_q;

  // --------------------------------------------------
  // valid flag
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      // sync clear, drops whatever sits here
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // payload only moves with a real item
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

  // stalled item stays put until taken
  a_hold_under_stall : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i && !flush_i |=> valid_o && $stable(data_o)
  );

endmodule

// File: src/divsqrt_ctrl.sv
// one operation at a time; the unit carries no tag, so the tag is kept here per operation
module divsqrt_ctrl (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           flush_i,
  // from the input stage
  divsqrt_req_if.consumer                req_in,
  // to the unit
  divsqrt_req_if.producer                req_out,
  // done pulse from the unit
  input  logic                           done_i,
  input  logic [divsqrt_pkg::DATA_W-1:0] unit_result_i,
  input  logic                           unit_dz_i,
  // to the output stage
  divsqrt_rsp_if.producer                rsp,
  output logic                           busy_o
);
  import divsqrt_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUSY,
    ST_HOLD
  } state_e;

  state_e            state_q;
  state_e            state_d;
  // room for a new operation this cycle
  logic              issue_ok;
  logic              start;
  logic              hold_en;
  logic              data_is_held;
  logic [TAG_W-1:0]  tag_q;
  logic [DATA_W-1:0] held_result_q;
  logic              held_dz_q;

  // --------------------------------------------------
  // issue side
  // --------------------------------------------------
  // new work only once the old result is gone
  always_comb begin
    unique case (state_q)
      ST_IDLE: issue_ok = 1'b1;
      ST_BUSY: issue_ok = done_i & rsp.ready;
      ST_HOLD: issue_ok = rsp.ready;
      default: issue_ok = 1'b0;
    endcase
  end

  assign req_out.valid    = req_in.valid & issue_ok & ~flush_i;
  assign req_out.op       = req_in.op;
  assign req_out.operands = req_in.operands;
  assign req_out.tag      = req_in.tag;
  // pop the input stage only when the unit takes it
  assign req_in.ready     = req_out.ready & issue_ok;

  assign start = req_out.valid & req_out.ready;

  // --------------------------------------------------
  // FSM
  // --------------------------------------------------
  always_comb begin
    state_d = state_q;
    hold_en = 1'b0;
    unique case (state_q)
      ST_IDLE: begin
        if (start) begin
          state_d = ST_BUSY;
        end
      end
      ST_BUSY: begin
        if (done_i) begin
          if (rsp.ready) begin
            // back to back when the next one is waiting
            state_d = start ? ST_BUSY : ST_IDLE;
          end else begin
            hold_en = 1'b1;
            state_d = ST_HOLD;
          end
        end
      end
      ST_HOLD: begin
        if (rsp.ready) begin
          state_d = start ? ST_BUSY : ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
    // flush wins over everything
    if (flush_i) begin
      state_d = ST_IDLE;
      hold_en = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // tag rides alongside the running operation
  always_ff @(posedge clk_i) begin
    if (start) begin
      tag_q <= req_in.tag;
    end
  end

  // hold register, filled when downstream stalls in the done cycle
  always_ff @(posedge clk_i) begin
    if (hold_en) begin
      held_result_q <= unit_result_i;
      held_dz_q     <= unit_dz_i;
    end
  end

  // --------------------------------------------------
  // output select
  // --------------------------------------------------
  assign data_is_held = (state_q == ST_HOLD);

  assign rsp.valid  = ((state_q == ST_BUSY) & done_i | data_is_held) & ~flush_i;
  // held data first
  assign rsp.result = data_is_held ? held_result_q : unit_result_i;
  assign rsp.dz     = data_is_held ? held_dz_q : unit_dz_i;
  assign rsp.tag    = tag_q;

  assign busy_o = (state_q != ST_IDLE);

  // a done pulse must belong to an operation this FSM started
  a_no_done_when_idle : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    done_i |-> state_q != ST_IDLE
  );

endmodule

// File: src/divsqrt_iter_unit.sv
// radix-2, fixed NUM_ITER steps; divide by zero runs the full length and returns all ones
module divsqrt_iter_unit (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           flush_i,
  // start port, ready means idle
  divsqrt_req_if.consumer                req,
  // one-cycle done with result
  output logic                           done_o,
  output logic [divsqrt_pkg::DATA_W-1:0] result_o,
  output logic                           dz_o
);
  import divsqrt_pkg::*;

  logic                             start;
  logic                             step;
  logic                             running_q;
  logic                             done_q;
  logic [$clog2(NUM_ITER+1)-1:0]    cnt_q;
  divsqrt_op_e                      op_q;
  logic                             dz_q;
  // source bits, consumed from the top
  logic [RAD_W-1:0]                 rad_q;
  logic [DATA_W-1:0]                dvs_q;
  // partial remainder, 33 bits cover 2 * root
  logic [DATA_W:0]                  rem_q;
  // quotient or root, built lsb first
  logic [DATA_W-1:0]                res_q;
  logic [DATA_W+2:0]                part;
  logic [DATA_W+2:0]                trial;
  logic [DATA_W+3:0]                diff;
  logic                             take;
  logic [DATA_W+2:0]                rem_next;

  assign req.ready = ~running_q;
  assign start     = req.valid & req.ready;
  assign step      = running_q & (cnt_q != '0);

  // --------------------------------------------------
  // sequencing
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      running_q <= 1'b0;
      done_q    <= 1'b0;
      cnt_q     <= '0;
    end else if (flush_i) begin
      // abort, nothing reported
      running_q <= 1'b0;
      done_q    <= 1'b0;
      cnt_q     <= '0;
    end else begin
      done_q <= 1'b0;
      if (start) begin
        running_q <= 1'b1;
        cnt_q     <= ($clog2(NUM_ITER+1))'(NUM_ITER);
      end else if (running_q) begin
        if (cnt_q == '0) begin
          // last step went in one cycle ago
          running_q <= 1'b0;
          done_q    <= 1'b1;
        end else begin
          cnt_q <= cnt_q - 1'b1;
        end
      end
    end
  end

  // --------------------------------------------------
  // one recurrence step
  // --------------------------------------------------
  always_comb begin
    if (op_q == OP_DIV) begin
      // shift in one dividend bit, try the divisor
      part  = {2'b00, rem_q[DATA_W-1:0], rad_q[RAD_W-1]};
      trial = {3'b000, dvs_q};
    end else begin
      // two radicand bits down, try 4*root + 1
      part  = {rem_q, rad_q[RAD_W-1 -: 2]};
      trial = {1'b0, res_q, 2'b01};
    end
    diff     = {1'b0, part} - {1'b0, trial};
    // no borrow, subtraction holds
    take     = ~diff[DATA_W+3];
    rem_next = take ? diff[DATA_W+2:0] : part;
  end

  // datapath registers
  always_ff @(posedge clk_i) begin
    if (start) begin
      op_q  <= req.op;
      dvs_q <= req.operands.div.divisor;
      // zero divisor flagged up front
      dz_q  <= (req.op == OP_DIV) && (req.operands.div.divisor == '0);
      rem_q <= '0;
      res_q <= '0;
      if (req.op == OP_DIV) begin
        rad_q <= {req.operands.div.dividend, {DATA_W{1'b0}}};
      end else begin
        rad_q <= req.operands.radicand;
      end
    end else if (step) begin
      rem_q <= rem_next[DATA_W:0];
      res_q <= {res_q[DATA_W-2:0], take};
      if (op_q == OP_DIV) begin
        rad_q <= {rad_q[RAD_W-2:0], 1'b0};
      end else begin
        rad_q <= {rad_q[RAD_W-3:0], 2'b00};
      end
    end
  end

  assign done_o   = done_q;
  assign result_o = res_q;
  assign dz_o     = dz_q;

  // closed for the whole run, then done in the cycle ready comes back
  a_run_length : assert property (
    @(posedge clk_i) disable iff (!rst_n_i || flush_i)
    start |=> !req.ready [*(NUM_ITER+1)] ##1 done_o
  );

  a_done_single : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    done_o |=> !done_o
  );

endmodule

// File: src/divsqrt_top.sv
// one operation in the unit at a time; up to three items in flight counting both stages
module divsqrt_top (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           flush_i,
  // request side
  input  logic                           in_valid_i,
  output logic                           in_ready_o,
  input  divsqrt_pkg::divsqrt_op_e       op_i,
  input  divsqrt_pkg::operand_u          operands_i,
  input  logic [divsqrt_pkg::TAG_W-1:0]  tag_i,
  // response side
  output logic                           out_valid_o,
  input  logic                           out_ready_i,
  output logic [divsqrt_pkg::DATA_W-1:0] result_o,
  output logic                           dz_o,
  output logic [divsqrt_pkg::TAG_W-1:0]  tag_o,
  // anything in flight
  output logic                           busy_o
);
  import divsqrt_pkg::*;

  req_payload_t      in_payload;
  req_payload_t      in_stage_data;
  rsp_payload_t      rsp_payload;
  rsp_payload_t      out_payload;
  logic              ctrl_busy;
  logic              unit_done;
  logic [DATA_W-1:0] unit_result;
  logic              unit_dz;

  divsqrt_req_if req_in_if ();
  divsqrt_req_if req_unit_if ();
  divsqrt_rsp_if rsp_if ();

  // --------------------------------------------------
  // input stage
  // --------------------------------------------------
  assign in_payload.op       = op_i;
  assign in_payload.operands = operands_i;
  assign in_payload.tag      = tag_i;

  divsqrt_pipe_reg #(
    .payload_t (req_payload_t)
  ) u_in_stage (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .valid_i (in_valid_i),
    .ready_o (in_ready_o),
    .data_i  (in_payload),
    .valid_o (req_in_if.valid),
    .ready_i (req_in_if.ready),
    .data_o  (in_stage_data)
  );

  // unpack onto the bundle
  assign req_in_if.op       = in_stage_data.op;
  assign req_in_if.operands = in_stage_data.operands;
  assign req_in_if.tag      = in_stage_data.tag;

  // --------------------------------------------------
  // controller and unit
  // --------------------------------------------------
  divsqrt_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .req_in        (req_in_if.consumer),
    .req_out       (req_unit_if.producer),
    .done_i        (unit_done),
    .unit_result_i (unit_result),
    .unit_dz_i     (unit_dz),
    .rsp           (rsp_if.producer),
    .busy_o        (ctrl_busy)
  );

  divsqrt_iter_unit u_unit (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .flush_i  (flush_i),
    .req      (req_unit_if.consumer),
    .done_o   (unit_done),
    .result_o (unit_result),
    .dz_o     (unit_dz)
  );

  // --------------------------------------------------
  // output stage
  // --------------------------------------------------
  assign rsp_payload.result = rsp_if.result;
  assign rsp_payload.dz     = rsp_if.dz;
  assign rsp_payload.tag    = rsp_if.tag;

  divsqrt_pipe_reg #(
    .payload_t (rsp_payload_t)
  ) u_out_stage (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .valid_i (rsp_if.valid),
    .ready_o (rsp_if.ready),
    .data_i  (rsp_payload),
    .valid_o (out_valid_o),
    .ready_i (out_ready_i),
    .data_o  (out_payload)
  );

  assign result_o = out_payload.result;
  assign dz_o     = out_payload.dz;
  assign tag_o    = out_payload.tag;

  // either stage holding an item, or the controller mid-operation
  assign busy_o = req_in_if.valid | ctrl_busy | out_valid_o;

endmodule

// File: verification/divsqrt_checker.sv
// compares in acceptance order; transfers on a flush edge are ignored and the queue is dropped
module divsqrt_checker (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           flush_i,
  // DUT request side, all inputs here
  input  logic                           in_valid_i,
  input  logic                           in_ready_i,
  input  divsqrt_pkg::divsqrt_op_e       op_i,
  input  divsqrt_pkg::operand_u          operands_i,
  input  logic [divsqrt_pkg::TAG_W-1:0]  in_tag_i,
  // DUT response side
  input  logic                           out_valid_i,
  input  logic                           out_ready_i,
  input  logic [divsqrt_pkg::DATA_W-1:0] result_i,
  input  logic                           dz_i,
  input  logic [divsqrt_pkg::TAG_W-1:0]  out_tag_i,
  input  logic                           busy_i,
  // counts for the closing line
  output int                             error_count_o,
  output int                             check_count_o,
  output int                             pending_o
);
  import divsqrt_pkg::*;

  rsp_payload_t expected_q[$];
  int           errors = 0;
  int           checks = 0;
  int           pending = 0;
  logic         was_in_reset = 1'b0;
  logic         after_flush = 1'b0;

  assign error_count_o = errors;
  assign check_count_o = checks;
  assign pending_o     = pending;

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------
  // bit by bit search, largest root whose square fits
  function automatic logic [DATA_W-1:0] floor_sqrt(input logic [RAD_W-1:0] rad);
    logic [DATA_W-1:0] root;
    logic [DATA_W-1:0] cand;
    logic [RAD_W-1:0]  cand_wide;
    root = '0;
    for (int b = DATA_W - 1; b >= 0; b--) begin
      cand      = root;
      cand[b]   = 1'b1;
      cand_wide = cand;
      if (cand_wide * cand_wide <= rad) begin
        root = cand;
      end
    end
    return root;
  endfunction

  function automatic rsp_payload_t model_result(input divsqrt_op_e op,
                                                input operand_u opd,
                                                input logic [TAG_W-1:0] tag);
    rsp_payload_t expected;
    expected.tag = tag;
    expected.dz  = 1'b0;
    if (op == OP_SQRT) begin
      expected.result = floor_sqrt(opd.radicand);
    end else if (opd.div.divisor == '0) begin
      // zero divisor, all ones plus the flag
      expected.result = '1;
      expected.dz     = 1'b1;
    end else begin
      expected.result = opd.div.dividend / opd.div.divisor;
    end
    return expected;
  endfunction

  task automatic report_mismatch(input string sig, input logic [DATA_W-1:0] want,
                                 input logic [DATA_W-1:0] got);
    errors++;
    $display("[FAIL] t=%0t %s expected 0x%0h actual 0x%0h", $time, sig, want, got);
  endtask

  // --------------------------------------------------
  // monitor, pre-edge values
  // --------------------------------------------------
  always @(posedge clk_i) begin
    rsp_payload_t expected;
    if (!rst_n_i) begin
      was_in_reset = 1'b1;
      after_flush  = 1'b0;
      expected_q.delete();
    end else begin
      // first edge out of reset, DUT must look idle
      if (was_in_reset) begin
        if (out_valid_i !== 1'b0) report_mismatch("out_valid_o", 0, out_valid_i);
        if (busy_i !== 1'b0) report_mismatch("busy_o", 0, busy_i);
        if (in_ready_i !== 1'b1) report_mismatch("in_ready_o", 1, in_ready_i);
        was_in_reset = 1'b0;
      end
      // flush leaves nothing behind
      if (after_flush && busy_i !== 1'b0) report_mismatch("busy_o", 0, busy_i);
      after_flush = 1'b0;
      // owed results keep busy up
      if (expected_q.size() != 0 && busy_i !== 1'b1) report_mismatch("busy_o", 1, busy_i);
      if (flush_i) begin
        expected_q.delete();
        after_flush = 1'b1;
      end else begin
        if (out_valid_i && out_ready_i) begin
          if (expected_q.size() == 0) begin
            errors++;
            $display("result delivered at time %0t with no operation pending", $time);
          end else begin
            expected = expected_q.pop_front();
            checks++;
            if (result_i !== expected.result) report_mismatch("result_o", expected.result, result_i);
            if (dz_i !== expected.dz) report_mismatch("dz_o", expected.dz, dz_i);
            if (out_tag_i !== expected.tag) report_mismatch("tag_o", expected.tag, out_tag_i);
          end
        end
        if (in_valid_i && in_ready_i) begin
          expected_q.push_back(model_result(op_i, operands_i, in_tag_i));
        end
      end
    end
    pending = expected_q.size();
  end

endmodule

// File: verification/tb_divsqrt.sv
// one LCG stream drives ops, gaps and stalls; flushes only go out with both handshakes idle
module tb_divsqrt;
  import divsqrt_pkg::*;

  localparam int NUM_OPS      = 200;
  localparam int ACCEPT_LIMIT = 500;
  localparam int DRAIN_LIMIT  = 5000;

  logic              clk;
  logic              rst_n;
  logic              flush;
  logic              in_valid;
  logic              in_ready;
  divsqrt_op_e       op;
  operand_u          operands;
  logic [TAG_W-1:0]  tag;
  logic              out_valid;
  logic              out_ready;
  logic [DATA_W-1:0] result;
  logic              dz;
  logic [TAG_W-1:0]  out_tag;
  logic              busy;
  logic [31:0]       lcg_state;
  // random stalls on the response side
  logic              stall_en;
  int                error_count;
  int                check_count;
  int                pending;

  divsqrt_top u_dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .flush_i     (flush),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .op_i        (op),
    .operands_i  (operands),
    .tag_i       (tag),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .result_o    (result),
    .dz_o        (dz),
    .tag_o       (out_tag),
    .busy_o      (busy)
  );

  divsqrt_checker u_checker (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .flush_i       (flush),
    .in_valid_i    (in_valid),
    .in_ready_i    (in_ready),
    .op_i          (op),
    .operands_i    (operands),
    .in_tag_i      (tag),
    .out_valid_i   (out_valid),
    .out_ready_i   (out_ready),
    .result_i      (result),
    .dz_i          (dz),
    .out_tag_i     (out_tag),
    .busy_i        (busy),
    .error_count_o (error_count),
    .check_count_o (check_count),
    .pending_o     (pending)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------------------------------------
  // stimulus helpers
  // --------------------------------------------------
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // falling edge, new stall decision
  task automatic tick();
    logic [31:0] r;
    @(negedge clk);
    if (stall_en) begin
      r         = next_rand();
      out_ready = (r[31:30] != 2'b00);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout at time %0t, gave up waiting for %s", $time, what);
    $display("checks: %0d, errors: %0d", check_count, error_count + 1);
    $display("Regression failed");
    $finish;
  endtask

  // hold the item until the DUT takes it
  task automatic send_op(input divsqrt_op_e op_v, input operand_u opd_v,
                         input logic [TAG_W-1:0] tag_v);
    int   waited;
    logic taken;
    waited   = 0;
    taken    = 1'b0;
    in_valid = 1'b1;
    op       = op_v;
    operands = opd_v;
    tag      = tag_v;
    while (!taken) begin
      @(posedge clk);
      taken = in_ready;
      tick();
      waited++;
      if (!taken && waited > ACCEPT_LIMIT) stop_on_timeout("in_ready_o");
    end
    in_valid = 1'b0;
  endtask

  task automatic send_random_op();
    logic [31:0] r;
    logic [31:0] dividend;
    logic [31:0] divisor;
    logic [31:0] rad_hi;
    logic [31:0] rad_lo;
    logic [63:0] radicand;
    r        = next_rand();
    dividend = next_rand();
    // shifted divisors spread the quotient sizes
    divisor  = next_rand() >> r[27:23];
    // about one in sixteen
    if (r[22:19] == 4'h0) divisor = '0;
    rad_hi   = next_rand();
    rad_lo   = next_rand();
    radicand = {rad_hi, rad_lo} >> r[18:13];
    if (r[31]) begin
      send_op(OP_SQRT, radicand, r[12:9]);
    end else begin
      send_op(OP_DIV, {dividend, divisor}, r[12:9]);
    end
  endtask

  task automatic flush_pipeline();
    in_valid  = 1'b0;
    out_ready = 1'b0;
    flush     = 1'b1;
    @(negedge clk);
    flush     = 1'b0;
    tick();
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    logic [31:0] r;
    int          waited;
    lcg_state = 32'd90;
    stall_en  = 1'b0;
    rst_n     = 1'b0;
    flush     = 1'b0;
    in_valid  = 1'b0;
    op        = OP_DIV;
    operands  = '0;
    tag       = '0;
    out_ready = 1'b1;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    tick();
    // corners first, no stalls
    send_op(OP_DIV, {32'hffff_ffff, 32'h0000_0001}, 4'h1);
    send_op(OP_DIV, {32'h1234_5678, 32'h0000_0000}, 4'h2);
    send_op(OP_SQRT, 64'hffff_ffff_ffff_ffff, 4'h3);
    send_op(OP_SQRT, 64'h0, 4'h4);
    stall_en = 1'b1;
    for (int i = 0; i < NUM_OPS; i++) begin
      if (i == 70 || i == 140) flush_pipeline();
      send_random_op();
      r = next_rand();
      if (r[31:30] == 2'b00) begin
        repeat (int'(r[29:28]) + 1) tick();
      end
    end
    // let everything out
    stall_en  = 1'b0;
    out_ready = 1'b1;
    waited    = 0;
    while (pending != 0) begin
      tick();
      waited++;
      if (waited > DRAIN_LIMIT) stop_on_timeout("outstanding results");
    end
    repeat (4) tick();
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: flist.f
src/divsqrt_pkg.sv
src/divsqrt_intf.sv
src/divsqrt_pipe_reg.sv
src/divsqrt_ctrl.sv
src/divsqrt_iter_unit.sv
src/divsqrt_top.sv
verification/divsqrt_checker.sv
verification/tb_divsqrt.sv

// File: Bender.yml
package:
  name: divsqrt

sources:
  - src/divsqrt_pkg.sv
  - src/divsqrt_intf.sv
  - src/divsqrt_pipe_reg.sv
  - src/divsqrt_ctrl.sv
  - src/divsqrt_iter_unit.sv
  - src/divsqrt_top.sv
  - target: test
    files:
      - verification/divsqrt_checker.sv
      - verification/tb_divsqrt.sv
